// ==== xbar_params.svh ====
// Bus widths and slave address map for the 2x3 Wishbone crossbar; include where decoding is done
`ifndef XBAR_PARAMS_SVH
`define XBAR_PARAMS_SVH

// Wishbone bus widths
`define WB_ADDR_W 32
`define WB_DATA_W 32

// Slave 0 window, 4 KiB
`define S0_BASE  32'h0000_0000
`define S0_LIMIT 32'h0000_0FFF

// Slave 1 window, 4 KiB right above slave 0
`define S1_BASE  32'h0000_1000
`define S1_LIMIT 32'h0000_1FFF

// Slave 2 window, 64 KiB
// Limits are inclusive and the first match wins
`define S2_BASE  32'h0001_0000
`define S2_LIMIT 32'h0001_FFFF

`endif

// ==== wb_pkg.sv ====
// Wishbone field types shared by the crossbar RTL and testbench; import with wb_pkg::*
`include "xbar_params.svh"

package wb_pkg;

	// Byte address as driven on ADR
	typedef logic [`WB_ADDR_W-1:0] wb_addr_t;

	// One data word, used for both DAT_W and DAT_R
	typedef logic [`WB_DATA_W-1:0] wb_data_t;

	// One select bit per data byte
	typedef logic [`WB_DATA_W/8-1:0] wb_sel_t;

endpackage

// ==== xbar_pkg.sv ====
// Crossbar routing and control types; import with xbar_pkg::* in the decoder, arbiter and router

package xbar_pkg;

	// Target a master's current cycle goes to
	// Low two bits of S0..ERR double as the target index in the router
	typedef enum logic [2:0] {
		TGT_S0   = 3'd0,
		TGT_S1   = 3'd1,
		TGT_S2   = 3'd2,
		TGT_ERR  = 3'd3,
		TGT_NONE = 3'd4
	} target_e;

	// Per-master cycle tracker
	typedef enum logic {
		DEC_IDLE = 1'b0,
		DEC_WAIT = 1'b1
	} dec_state_e;

	// Decode-fail responder
	typedef enum logic {
		ERR_IDLE = 1'b0,
		ERR_RESP = 1'b1
	} err_state_e;

	// Index of one of the two masters
	typedef logic master_id_t;

endpackage

// ==== wb_addr_decode.sv ====
// Per-master address decoder; latches the addressed target for one Wishbone cycle until ACK or ERR
`timescale 1ns/10ps
`include "xbar_params.svh"

module wb_addr_decode
	import wb_pkg::*;
	import xbar_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	input  logic     cyc_i,
	input  logic     stb_i,
	input  wb_addr_t adr_i,
	// Routed completion of this master's cycle
	input  logic     ack_i,
	input  logic     err_i,
	output target_e  target_o
);

	dec_state_e state;
	target_e    adr_tgt;

	// Address map lookup
	// First matching window wins, no match goes to the decode-fail target
	always_comb begin
		if (adr_i >= `S0_BASE && adr_i <= `S0_LIMIT) begin
			adr_tgt = TGT_S0;
		end else if (adr_i >= `S1_BASE && adr_i <= `S1_LIMIT) begin
			adr_tgt = TGT_S1;
		end else if (adr_i >= `S2_BASE && adr_i <= `S2_LIMIT) begin
			adr_tgt = TGT_S2;
		end else begin
			adr_tgt = TGT_ERR;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state    <= DEC_IDLE;
			target_o <= TGT_NONE;
		end else begin
			case (state)
				DEC_IDLE: begin
					// New strobed request, capture where it goes
					if (cyc_i && stb_i) begin
						state    <= DEC_WAIT;
						target_o <= adr_tgt;
					end
				end
				DEC_WAIT: begin
					// Hold the target through slave wait states
					// A dropped CYC abandons the cycle as well
					if (ack_i || err_i || !cyc_i) begin
						state    <= DEC_IDLE;
						target_o <= TGT_NONE;
					end
				end
			endcase
		end
	end

endmodule

// ==== wb_rr_arbiter.sv ====
// Two-requester round-robin arbiter for one crossbar target; grant is held until the owner lets go
`timescale 1ns/10ps

module wb_rr_arbiter
	import xbar_pkg::*;
(
	input  logic       clk,
	input  logic       rstn,
	// One bit per master, high while it addresses this target
	input  logic [1:0] req_i,
	output logic       gnt_o,
	output master_id_t gnt_id_o
);

	// Candidate for the next grant
	master_id_t pick_id;
	logic       pick_vld;

	// gnt_id_o keeps the last owner after release
	// so it also serves as the round-robin pointer
	always_comb begin
		pick_vld = |req_i;
		// Requester after the last owner goes first
		if (req_i[~gnt_id_o]) begin
			pick_id = ~gnt_id_o;
		end else begin
			pick_id = gnt_id_o;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o    <= 1'b0;
			// Points at master 1, so master 0 wins the first tie
			gnt_id_o <= 1'b1;
		end else begin
			if (!gnt_o) begin
				// Free target, register the winner
				if (pick_vld) begin
					gnt_o    <= 1'b1;
					gnt_id_o <= pick_id;
				end
			end else begin
				// Owner's request gone, release
				// Re-arbitration happens on the following edge
				if (!req_i[gnt_id_o]) begin
					gnt_o <= 1'b0;
				end
			end
		end
	end

endmodule

// ==== wb_xbar_route.sv ====
// Crossbar routing core; arbitrates each target, muxes requests and responses, answers decode fails
`timescale 1ns/10ps

module wb_xbar_route
	import wb_pkg::*;
	import xbar_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	// Decoded targets of the two masters
	input  target_e  tgt0_i,
	input  target_e  tgt1_i,
	// Master 0
	input  logic     m0_cyc_i, m0_stb_i, m0_we_i,
	input  wb_addr_t m0_adr_i,
	input  wb_data_t m0_dat_i,
	input  wb_sel_t  m0_sel_i,
	output wb_data_t m0_dat_o,
	output logic     m0_ack_o, m0_err_o,
	// Master 1
	input  logic     m1_cyc_i, m1_stb_i, m1_we_i,
	input  wb_addr_t m1_adr_i,
	input  wb_data_t m1_dat_i,
	input  wb_sel_t  m1_sel_i,
	output wb_data_t m1_dat_o,
	output logic     m1_ack_o, m1_err_o,
	// Slave 0
	output logic     s0_cyc_o, s0_stb_o, s0_we_o,
	output wb_addr_t s0_adr_o,
	output wb_data_t s0_dat_o,
	output wb_sel_t  s0_sel_o,
	input  wb_data_t s0_dat_i,
	input  logic     s0_ack_i, s0_err_i,
	// Slave 1
	output logic     s1_cyc_o, s1_stb_o, s1_we_o,
	output wb_addr_t s1_adr_o,
	output wb_data_t s1_dat_o,
	output wb_sel_t  s1_sel_o,
	input  wb_data_t s1_dat_i,
	input  logic     s1_ack_i, s1_err_i,
	// Slave 2
	output logic     s2_cyc_o, s2_stb_o, s2_we_o,
	output wb_addr_t s2_adr_o,
	output wb_data_t s2_dat_o,
	output wb_sel_t  s2_sel_o,
	input  wb_data_t s2_dat_i,
	input  logic     s2_ack_i, s2_err_i
);

	// Three slaves plus the decode-fail target
	localparam int N_SLV = 3;
	localparam int N_TGT = 4;
	// Slot of the decode-fail target in the per-target arrays
	localparam int T_ERR = int'(TGT_ERR);

	// Master request side, indexed by master
	logic       m_cyc  [2];
	logic       m_stb  [2];
	logic       m_we   [2];
	wb_addr_t   m_adr  [2];
	wb_data_t   m_wdat [2];
	wb_sel_t    m_sel  [2];
	target_e    m_tgt  [2];

	// Arbitration and handshake per target
	logic [1:0] t_req    [N_TGT];
	logic       t_gnt    [N_TGT];
	master_id_t t_gnt_id [N_TGT];
	logic       t_act    [N_TGT];
	logic       t_cyc    [N_TGT];
	logic       t_stb    [N_TGT];
	wb_data_t   t_rdat   [N_TGT];
	logic       t_ack    [N_TGT];
	logic       t_err    [N_TGT];

	// Request payload, only real slaves need it
	logic       s_we   [N_SLV];
	wb_addr_t   s_adr  [N_SLV];
	wb_data_t   s_wdat [N_SLV];
	wb_sel_t    s_sel  [N_SLV];

	// Response path back to each master
	logic [1:0] m_tidx [2];
	logic       m_hit  [2];

	err_state_e err_state;

	// Gather master inputs
	assign m_cyc[0]  = m0_cyc_i;
	assign m_cyc[1]  = m1_cyc_i;
	assign m_stb[0]  = m0_stb_i;
	assign m_stb[1]  = m1_stb_i;
	assign m_we[0]   = m0_we_i;
	assign m_we[1]   = m1_we_i;
	assign m_adr[0]  = m0_adr_i;
	assign m_adr[1]  = m1_adr_i;
	assign m_wdat[0] = m0_dat_i;
	assign m_wdat[1] = m1_dat_i;
	assign m_sel[0]  = m0_sel_i;
	assign m_sel[1]  = m1_sel_i;
	assign m_tgt[0]  = tgt0_i;
	assign m_tgt[1]  = tgt1_i;

	for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
		// Bit m set while master m's cycle targets t
		assign t_req[t] = {m_tgt[1] == target_e'(t), m_tgt[0] == target_e'(t)};

		wb_rr_arbiter u_arb (
			.clk      (clk),
			.rstn     (rstn),
			.req_i    (t_req[t]),
			.gnt_o    (t_gnt[t]),
			.gnt_id_o (t_gnt_id[t])
		);

		// Owner still addresses this target
		// Masks the cycle between completion and grant release
		assign t_act[t] = t_gnt[t] && t_req[t][t_gnt_id[t]];
		assign t_cyc[t] = t_act[t] && m_cyc[t_gnt_id[t]];
		assign t_stb[t] = t_act[t] && m_stb[t_gnt_id[t]];
	end

	// Payload mux, all zero when no owner
	for (genvar s = 0; s < N_SLV; s++) begin : g_slv
		assign s_we[s]   = t_act[s] && m_we[t_gnt_id[s]];
		assign s_adr[s]  = t_act[s] ? m_adr[t_gnt_id[s]] : '0;
		assign s_wdat[s] = t_act[s] ? m_wdat[t_gnt_id[s]] : '0;
		assign s_sel[s]  = t_act[s] ? m_sel[t_gnt_id[s]] : '0;
	end

	// Slave ports
	assign s0_cyc_o = t_cyc[0];
	assign s0_stb_o = t_stb[0];
	assign s0_we_o  = s_we[0];
	assign s0_adr_o = s_adr[0];
	assign s0_dat_o = s_wdat[0];
	assign s0_sel_o = s_sel[0];
	assign s1_cyc_o = t_cyc[1];
	assign s1_stb_o = t_stb[1];
	assign s1_we_o  = s_we[1];
	assign s1_adr_o = s_adr[1];
	assign s1_dat_o = s_wdat[1];
	assign s1_sel_o = s_sel[1];
	assign s2_cyc_o = t_cyc[2];
	assign s2_stb_o = t_stb[2];
	assign s2_we_o  = s_we[2];
	assign s2_adr_o = s_adr[2];
	assign s2_dat_o = s_wdat[2];
	assign s2_sel_o = s_sel[2];

	// Slave responses
	assign t_rdat[0] = s0_dat_i;
	assign t_ack[0]  = s0_ack_i;
	assign t_err[0]  = s0_err_i;
	assign t_rdat[1] = s1_dat_i;
	assign t_ack[1]  = s1_ack_i;
	assign t_err[1]  = s1_err_i;
	assign t_rdat[2] = s2_dat_i;
	assign t_ack[2]  = s2_ack_i;
	assign t_err[2]  = s2_err_i;

	// Decode-fail target, one ERR beat per granted strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			err_state <= ERR_IDLE;
		end else begin
			case (err_state)
				ERR_IDLE: begin
					if (t_cyc[T_ERR] && t_stb[T_ERR]) begin
						err_state <= ERR_RESP;
					end
				end
				ERR_RESP: begin
					err_state <= ERR_IDLE;
				end
			endcase
		end
	end

	assign t_rdat[T_ERR] = '0;
	assign t_ack[T_ERR]  = 1'b0;
	assign t_err[T_ERR]  = (err_state == ERR_RESP);

	for (genvar m = 0; m < 2; m++) begin : g_mst
		// Target index, valid unless TGT_NONE
		assign m_tidx[m] = m_tgt[m][1:0];
		// Response only passes once this master owns its target
		assign m_hit[m]  = (m_tgt[m] != TGT_NONE) && t_gnt[m_tidx[m]] &&
			(t_gnt_id[m_tidx[m]] == master_id_t'(m));
	end

	// Master responses, combinational from the owned target
	assign m0_dat_o = m_hit[0] ? t_rdat[m_tidx[0]] : '0;
	assign m0_ack_o = m_hit[0] && t_ack[m_tidx[0]];
	assign m0_err_o = m_hit[0] && t_err[m_tidx[0]];
	assign m1_dat_o = m_hit[1] ? t_rdat[m_tidx[1]] : '0;
	assign m1_ack_o = m_hit[1] && t_ack[m_tidx[1]];
	assign m1_err_o = m_hit[1] && t_err[m_tidx[1]];

endmodule

// ==== wb_xbar_2x3.sv ====
// Top of the 2-master 3-slave Wishbone classic crossbar; instantiate with the m0/m1 and s0..s2 ports
`timescale 1ns/10ps

module wb_xbar_2x3
	import wb_pkg::*;
	import xbar_pkg::*;
(
	input  logic     clk,
	input  logic     rstn,
	// Master 0 port
	input  logic     m0_cyc_i, m0_stb_i, m0_we_i,
	input  wb_addr_t m0_adr_i,
	input  wb_data_t m0_dat_i,
	input  wb_sel_t  m0_sel_i,
	output wb_data_t m0_dat_o,
	output logic     m0_ack_o, m0_err_o,
	// Master 1 port
	input  logic     m1_cyc_i, m1_stb_i, m1_we_i,
	input  wb_addr_t m1_adr_i,
	input  wb_data_t m1_dat_i,
	input  wb_sel_t  m1_sel_i,
	output wb_data_t m1_dat_o,
	output logic     m1_ack_o, m1_err_o,
	// Slave 0 port
	output logic     s0_cyc_o, s0_stb_o, s0_we_o,
	output wb_addr_t s0_adr_o,
	output wb_data_t s0_dat_o,
	output wb_sel_t  s0_sel_o,
	input  wb_data_t s0_dat_i,
	input  logic     s0_ack_i, s0_err_i,
	// Slave 1 port
	output logic     s1_cyc_o, s1_stb_o, s1_we_o,
	output wb_addr_t s1_adr_o,
	output wb_data_t s1_dat_o,
	output wb_sel_t  s1_sel_o,
	input  wb_data_t s1_dat_i,
	input  logic     s1_ack_i, s1_err_i,
	// Slave 2 port
	output logic     s2_cyc_o, s2_stb_o, s2_we_o,
	output wb_addr_t s2_adr_o,
	output wb_data_t s2_dat_o,
	output wb_sel_t  s2_sel_o,
	input  wb_data_t s2_dat_i,
	input  logic     s2_ack_i, s2_err_i
);

	// Decoded target of each master's open cycle
	target_e tgt0;
	target_e tgt1;

	// Master 0 decoder, completion comes from its own routed ack/err
	wb_addr_decode u_dec0 (
		.clk      (clk),
		.rstn     (rstn),
		.cyc_i    (m0_cyc_i),
		.stb_i    (m0_stb_i),
		.adr_i    (m0_adr_i),
		.ack_i    (m0_ack_o),
		.err_i    (m0_err_o),
		.target_o (tgt0)
	);

	// Master 1 decoder, same map
	wb_addr_decode u_dec1 (
		.clk      (clk),
		.rstn     (rstn),
		.cyc_i    (m1_cyc_i),
		.stb_i    (m1_stb_i),
		.adr_i    (m1_adr_i),
		.ack_i    (m1_ack_o),
		.err_i    (m1_err_o),
		.target_o (tgt1)
	);

	// Bus ports share names with the top, so they bind by name
	wb_xbar_route u_route (
		.tgt0_i (tgt0),
		.tgt1_i (tgt1),
		.*
	);

endmodule

// ==== tb_wb_mem.sv ====
// Testbench Wishbone slave model; a 4 KiB word memory that ACKs after WAIT idle cycles
`timescale 1ns/10ps

module tb_wb_mem
	import wb_pkg::*;
#(
	// Cycles between seeing STB and raising ACK
	parameter int WAIT = 0
) (
	input  logic     clk,
	input  logic     rstn,
	input  logic     cyc_i,
	input  logic     stb_i,
	input  logic     we_i,
	input  wb_addr_t adr_i,
	input  wb_data_t dat_i,
	input  wb_sel_t  sel_i,
	output wb_data_t dat_o,
	output logic     ack_o,
	output logic     err_o
);

	wb_data_t   mem [1024];
	int         cnt;
	logic [9:0] idx;

	// Word index, upper address bits alias
	assign idx   = adr_i[11:2];
	assign err_o = 1'b0;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_o <= 1'b0;
			dat_o <= '0;
			cnt   <= 0;
		end else if (ack_o) begin
			// One ACK beat per strobe
			ack_o <= 1'b0;
			cnt   <= 0;
		end else if (cyc_i && stb_i) begin
			if (cnt == WAIT) begin
				ack_o <= 1'b1;
				cnt   <= 0;
				if (we_i) begin
					// Byte lanes follow SEL
					for (int b = 0; b < 4; b++) begin
						if (sel_i[b]) begin
							mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
						end
					end
				end else begin
					dat_o <= mem[idx];
				end
			end else begin
				cnt <= cnt + 1;
			end
		end else begin
			// Strobe gone, restart the wait count
			cnt <= 0;
		end
	end

endmodule

// ==== tb_xbar.sv ====
// Testbench top for the 2x3 Wishbone crossbar; simulate with tb_xbar as the top module
`timescale 1ns/10ps
`include "xbar_params.svh"

module tb_xbar
	import wb_pkg::*;
	import xbar_pkg::*;
();

	localparam int TIMEOUT = 200;

	logic     clk;
	logic     rstn;
	// Master side, indexed by master
	logic     m_cyc  [2];
	logic     m_stb  [2];
	logic     m_we   [2];
	wb_addr_t m_adr  [2];
	wb_data_t m_wdat [2];
	wb_sel_t  m_sel  [2];
	wb_data_t m_rdat [2];
	logic     m_ack  [2];
	logic     m_err  [2];
	// Slave side, indexed by slave
	logic     s_cyc  [3];
	logic     s_stb  [3];
	logic     s_we   [3];
	wb_addr_t s_adr  [3];
	wb_data_t s_wdat [3];
	wb_sel_t  s_sel  [3];
	wb_data_t s_rdat [3];
	logic     s_ack  [3];
	logic     s_err  [3];

	// Expected memory contents per slave
	wb_data_t shadow [3][1024];
	int       seed = 32'hc445;
	int       err_cnt = 0;
	int       err_mark = 0;
	int       n_pass = 0;
	int       n_fail = 0;
	int       stb_seen = 0;
	string    test_name = "none";
	int       done_q [$];
	wb_addr_t wrote_q [$];

	initial begin
		clk = 1'b0;
		forever begin
			#50;
			clk = ~clk;
		end
	end

	wb_xbar_2x3 uut (
		.clk      (clk),
		.rstn     (rstn),
		.m0_cyc_i (m_cyc[0]), .m0_stb_i (m_stb[0]), .m0_we_i (m_we[0]),
		.m0_adr_i (m_adr[0]), .m0_dat_i (m_wdat[0]), .m0_sel_i (m_sel[0]),
		.m0_dat_o (m_rdat[0]), .m0_ack_o (m_ack[0]), .m0_err_o (m_err[0]),
		.m1_cyc_i (m_cyc[1]), .m1_stb_i (m_stb[1]), .m1_we_i (m_we[1]),
		.m1_adr_i (m_adr[1]), .m1_dat_i (m_wdat[1]), .m1_sel_i (m_sel[1]),
		.m1_dat_o (m_rdat[1]), .m1_ack_o (m_ack[1]), .m1_err_o (m_err[1]),
		.s0_cyc_o (s_cyc[0]), .s0_stb_o (s_stb[0]), .s0_we_o (s_we[0]),
		.s0_adr_o (s_adr[0]), .s0_dat_o (s_wdat[0]), .s0_sel_o (s_sel[0]),
		.s0_dat_i (s_rdat[0]), .s0_ack_i (s_ack[0]), .s0_err_i (s_err[0]),
		.s1_cyc_o (s_cyc[1]), .s1_stb_o (s_stb[1]), .s1_we_o (s_we[1]),
		.s1_adr_o (s_adr[1]), .s1_dat_o (s_wdat[1]), .s1_sel_o (s_sel[1]),
		.s1_dat_i (s_rdat[1]), .s1_ack_i (s_ack[1]), .s1_err_i (s_err[1]),
		.s2_cyc_o (s_cyc[2]), .s2_stb_o (s_stb[2]), .s2_we_o (s_we[2]),
		.s2_adr_o (s_adr[2]), .s2_dat_o (s_wdat[2]), .s2_sel_o (s_sel[2]),
		.s2_dat_i (s_rdat[2]), .s2_ack_i (s_ack[2]), .s2_err_i (s_err[2])
	);

	// Slave memories with wait counts 0, 1 and 3
	for (genvar i = 0; i < 3; i++) begin : g_mem
		tb_wb_mem #(.WAIT(i == 2 ? 3 : i)) u_mem (
			.clk   (clk),
			.rstn  (rstn),
			.cyc_i (s_cyc[i]), .stb_i (s_stb[i]), .we_i (s_we[i]),
			.adr_i (s_adr[i]), .dat_i (s_wdat[i]), .sel_i (s_sel[i]),
			.dat_o (s_rdat[i]), .ack_o (s_ack[i]), .err_o (s_err[i])
		);
	end

	// Expected target from the address map, first window wins
	function automatic target_e ref_target(input wb_addr_t a);
		wb_addr_t lo [3];
		wb_addr_t hi [3];
		lo = '{`S0_BASE, `S1_BASE, `S2_BASE};
		hi = '{`S0_LIMIT, `S1_LIMIT, `S2_LIMIT};
		for (int i = 0; i < 3; i++) begin
			if (a >= lo[i] && a <= hi[i]) begin
				return target_e'(i);
			end
		end
		return TGT_ERR;
	endfunction

	// Random word address in slave s, each master gets its own half
	function automatic wb_addr_t rand_addr(input int s, input int m);
		wb_addr_t base;
		wb_data_t r;
		r = $random(seed);
		case (s)
			0:       base = `S0_BASE;
			1:       base = `S1_BASE;
			default: base = `S2_BASE;
		endcase
		return base + {20'd0, m[0], r[8:0], 2'b00};
	endfunction

	task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
			err_cnt++;
		end
	endtask

	task automatic check_idle();
		logic [9:0] v;
		v = {s_cyc[0], s_cyc[1], s_cyc[2], s_stb[0], s_stb[1], s_stb[2],
			m_ack[0], m_ack[1], m_err[0], m_err[1]};
		expect_eq("cyc/stb/ack/err", 32'd0, 32'(v));
	endtask

	// One classic cycle on master m, sampled at the falling edge
	// Request stays up after completion until the next cycle replaces it
	task automatic bus_cycle(input int m, input logic we, input wb_addr_t adr,
		input wb_data_t wdat, output wb_data_t rdat, output logic ack, output logic err);
		int n;
		@(posedge clk);
		#1;
		m_cyc[m]  = 1'b1;
		m_stb[m]  = 1'b1;
		m_we[m]   = we;
		m_adr[m]  = adr;
		m_wdat[m] = wdat;
		m_sel[m]  = '1;
		n    = 0;
		ack  = 1'b0;
		err  = 1'b0;
		rdat = '0;
		while (!ack && !err && n < TIMEOUT) begin
			@(negedge clk);
			ack  = m_ack[m];
			err  = m_err[m];
			rdat = m_rdat[m];
			n++;
		end
		if (!ack && !err) begin
			$display("Master %0d hung: no ACK or ERR within %0d cycles for address %h",
				m, TIMEOUT, adr);
			err_cnt++;
		end
	endtask

	// Drop the cycle one step after the last completing edge
	task automatic bus_release(input int m);
		@(posedge clk);
		#1;
		m_cyc[m] = 1'b0;
		m_stb[m] = 1'b0;
		m_we[m]  = 1'b0;
	endtask

	// Runs a cycle and compares its response with the address map and shadow
	task automatic access(input int m, input logic we, input wb_addr_t adr, input wb_data_t wdat);
		target_e  tgt;
		wb_data_t rdat;
		logic     ack;
		logic     err;
		tgt = ref_target(adr);
		bus_cycle(m, we, adr, wdat, rdat, ack, err);
		if (tgt == TGT_ERR) begin
			expect_eq($sformatf("m%0d err_o", m), 32'd1, 32'(err));
			expect_eq($sformatf("m%0d ack_o", m), 32'd0, 32'(ack));
			expect_eq($sformatf("m%0d dat_o", m), 32'd0, rdat);
		end else begin
			expect_eq($sformatf("m%0d ack_o", m), 32'd1, 32'(ack));
			expect_eq($sformatf("m%0d err_o", m), 32'd0, 32'(err));
			if (we) begin
				shadow[int'(tgt)][adr[11:2]] = wdat;
			end else begin
				expect_eq($sformatf("m%0d read %h", m, adr), shadow[int'(tgt)][adr[11:2]], rdat);
			end
		end
	endtask

	// Write then read back n random words of slave s, back to back
	task automatic run_stream(input int m, input int s, input int n);
		wb_addr_t a;
		wb_data_t d;
		for (int k = 0; k < n; k++) begin
			a = rand_addr(s, m);
			d = $random(seed);
			access(m, 1'b1, a, d);
			done_q.push_back(m);
			access(m, 1'b0, a, '0);
			done_q.push_back(m);
			if (m == 0) begin
				wrote_q.push_back(a);
			end
		end
		bus_release(m);
	endtask

	task automatic start_test(input string name);
		test_name = name;
		err_mark  = err_cnt;
	endtask

	task automatic finish_test();
		if (err_cnt == err_mark) begin
			n_pass++;
			$display("Test %s: pass", test_name);
		end else begin
			n_fail++;
			$display("Test %s: %0d errors", test_name, err_cnt - err_mark);
		end
	endtask

	// Every strobed slave address must lie in that slave's window
	always @(negedge clk) begin
		for (int s = 0; s < 3; s++) begin
			if (s_stb[s]) begin
				stb_seen++;
				if (ref_target(s_adr[s]) != target_e'(s)) begin
					$display("ERROR %s s%0d adr_o: expected target %0d, actual %0d (adr %h)",
						test_name, s, s, ref_target(s_adr[s]), s_adr[s]);
					err_cnt++;
				end
			end
		end
	end

	initial begin
		wb_data_t d;
		rstn = 1'b0;
		for (int m = 0; m < 2; m++) begin
			m_cyc[m]  = 1'b0;
			m_stb[m]  = 1'b0;
			m_we[m]   = 1'b0;
			m_adr[m]  = '0;
			m_wdat[m] = '0;
			m_sel[m]  = '0;
		end

		start_test("reset");
		repeat (8) begin
			@(posedge clk);
			#1;
			check_idle();
		end
		rstn = 1'b1;
		repeat (2) begin
			@(negedge clk);
			check_idle();
		end
		finish_test();

		start_test("m0_rw");
		for (int s = 0; s < 3; s++) begin
			run_stream(0, s, 4);
		end
		finish_test();

		// Master 1 also reads what master 0 wrote
		start_test("m1_rw");
		for (int s = 0; s < 3; s++) begin
			run_stream(1, s, 4);
		end
		foreach (wrote_q[i]) begin
			access(1, 1'b0, wrote_q[i], '0);
		end
		bus_release(1);
		finish_test();

		start_test("unmapped");
		stb_seen = 0;
		for (int m = 0; m < 2; m++) begin
			d = $random(seed);
			access(m, 1'b1, 32'h0000_2000, d);
			access(m, 1'b0, 32'h8000_0000, '0);
			access(m, 1'b0, 32'h0000_2000, '0);
			bus_release(m);
		end
		if (stb_seen != 0) begin
			$display("ERROR %s slave strobes: expected 0, actual %0d", test_name, stb_seen);
			err_cnt++;
		end
		finish_test();

		// Same slave from both masters, completions must alternate
		// Each master re-requests at once, so both are pending at every release
		start_test("contend");
		done_q.delete();
		fork
			run_stream(0, 2, 4);
			run_stream(1, 2, 4);
		join
		for (int i = 1; i < done_q.size(); i++) begin
			if (done_q[i] == done_q[i-1]) begin
				$display("ERROR %s completion %0d: expected master %0d, actual master %0d",
					test_name, i, 1 - done_q[i-1], done_q[i]);
				err_cnt++;
			end
		end
		finish_test();

		start_test("parallel");
		fork
			run_stream(0, 0, 6);
			run_stream(1, 1, 6);
		join
		finish_test();

		$display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, err_cnt);
		if (n_fail == 0 && err_cnt == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== list.f ====
+incdir+.
wb_pkg.sv
xbar_pkg.sv
wb_addr_decode.sv
wb_rr_arbiter.sv
wb_xbar_route.sv
wb_xbar_2x3.sv
tb_wb_mem.sv
tb_xbar.sv

// ==== run.sh ====
#!/bin/sh
# Builds the crossbar testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module tb_xbar -o tb_xbar

./obj_dir/tb_xbar | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "Simulation reported errors, see sim.log"
	exit 1
fi
echo "Simulation clean"
